// File: design/csb_pkg.sv
package csb_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int addr_w      = 16;         // word address
  localparam int data_w      = 32;
  localparam int page_w      = 6;
  localparam int page_lsb    = addr_w - page_w;  // page is addr[15:10]
  localparam int num_clients = 4;          // cfgrom, glb, mcif, cdma

  localparam int req_pd_w    = 63;
  localparam int resp_pd_w   = 34;

  ////////////////////////////////////////////////////////////
  // packet field positions
  ////////////////////////////////////////////////////////////
  // request: {7'b0, nposted, write, wdat, 6'b0, addr}
  localparam int req_addr_lsb    = 0;
  localparam int req_wdat_lsb    = 22;
  localparam int req_write_bit   = 54;
  localparam int req_nposted_bit = 55;

  // response: {type, error, data}
  localparam int resp_err_bit  = 32;
  localparam int resp_type_bit = 33;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////
  typedef logic [addr_w-1:0]      csb_addr_t;
  typedef logic [data_w-1:0]      csb_data_t;
  typedef logic [page_w-1:0]      csb_page_t;
  typedef logic [num_clients-1:0] client_hit_t;  // one-hot, zero means dummy
  typedef logic [req_pd_w-1:0]    req_pd_t;
  typedef logic [resp_pd_w-1:0]   resp_pd_t;

  typedef enum logic {
    resp_read  = 1'b0,
    resp_write = 1'b1
  } resp_type_e;

endpackage

// File: design/csb_core_req_if.sv
`timescale 1ns/100ps

interface csb_core_req_if;
  import csb_pkg::*;

  logic        vld;      // one pulse per captured request
  csb_addr_t   addr;
  csb_data_t   wdat;
  logic        write;
  logic        nposted;
  client_hit_t hit;      // decoded page

  modport capture (
    output vld, addr, wdat, write, nposted, hit
  );

  modport sink (
    input vld, addr, wdat, write, nposted, hit
  );

endinterface

// File: design/csb_req_capture.sv
`timescale 1ns/100ps

module csb_req_capture (
  input  logic               nvdla_core_clk,
  input  logic               nvdla_core_rstn,
  input  logic               csb2nvdla_valid,
  input  logic               csb2nvdla_write,
  input  logic               csb2nvdla_nposted,
  input  csb_pkg::csb_addr_t csb2nvdla_addr,
  input  csb_pkg::csb_data_t csb2nvdla_wdat,
  csb_core_req_if.capture    core_req
);
  import csb_pkg::*;

  logic        vld_q;
  csb_addr_t   addr_q;
  csb_data_t   wdat_q;
  logic        write_q;
  logic        nposted_q;
  csb_page_t   page;
  client_hit_t hit;

  // strobe, one request per cycle
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= csb2nvdla_valid;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb2nvdla_valid) begin
      addr_q    <= csb2nvdla_addr;
      wdat_q    <= csb2nvdla_wdat;
      write_q   <= csb2nvdla_write;
      nposted_q <= csb2nvdla_nposted;
    end
  end

  ////////////////////////////////////////////////////////////
  // page decode
  ////////////////////////////////////////////////////////////
  assign page = addr_q[page_lsb +: page_w];
  assign hit  = (page < csb_page_t'(num_clients)) ? (client_hit_t'(1) << page)
                                                  : '0;  // unmapped, dummy

  assign core_req.vld     = vld_q;
  assign core_req.addr    = addr_q;
  assign core_req.wdat    = wdat_q;
  assign core_req.write   = write_q;
  assign core_req.nposted = nposted_q;
  assign core_req.hit     = hit;

endmodule

// File: design/csb_client_slot.sv
`timescale 1ns/100ps

module csb_client_slot #(
  parameter int unsigned client_idx = 0
) (
  input  logic             nvdla_core_clk,
  input  logic             nvdla_core_rstn,
  csb_core_req_if.sink     core_req,
  output logic             req_pvld,
  input  logic             req_prdy,
  output csb_pkg::req_pd_t req_pd
);
  import csb_pkg::*;

  logic      take;
  logic      out_free;
  logic      load_out;
  logic      pend;
  csb_addr_t pend_addr;
  csb_data_t pend_wdat;
  logic      pend_write;
  logic      pend_nposted;
  req_pd_t   pack_pd;
  req_pd_t   pd_q;

  assign take     = core_req.vld & core_req.hit[client_idx];
  assign out_free = req_prdy | ~req_pvld;      // output empty or draining
  assign load_out = pend & out_free;

  ////////////////////////////////////////////////////////////
  // pending stage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pend <= 1'b0;
    end else if (take) begin
      pend <= 1'b1;
    end else if (out_free) begin
      pend <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (take) begin
      pend_addr    <= core_req.addr;
      pend_wdat    <= core_req.wdat;
      pend_write   <= core_req.write;
      pend_nposted <= core_req.nposted;
    end
  end

  // unused fields stay zero
  always_comb begin
    pack_pd = '0;
    pack_pd[req_addr_lsb +: addr_w] = pend_addr;
    pack_pd[req_wdat_lsb +: data_w] = pend_wdat;
    pack_pd[req_write_bit]          = pend_write;
    pack_pd[req_nposted_bit]        = pend_nposted;
  end

  ////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else if (pend) begin
      req_pvld <= 1'b1;
    end else if (req_prdy) begin
      req_pvld <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (load_out) begin
      pd_q <= pack_pd;  // held while stalled
    end
  end

  assign req_pd = pd_q;

  // a third request would overwrite the waiting one
  a_no_lost_req: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(take && pend && req_pvld && !req_prdy))
    else $error("csb slot %0d: request lost, both stages full", client_idx);

endmodule

// File: design/csb_dummy_client.sv
`timescale 1ns/100ps

module csb_dummy_client (
  input  logic              nvdla_core_clk,
  input  logic              nvdla_core_rstn,
  csb_core_req_if.sink      core_req,
  output logic              resp_valid,
  output csb_pkg::resp_pd_t resp_pd
);
  import csb_pkg::*;

  logic       take;
  logic       req_vld;
  logic       req_read;
  logic       req_nposted;
  logic       resp_vld_nxt;
  resp_type_e resp_type_nxt;
  resp_type_e resp_type;

  assign take = core_req.vld & ~(|core_req.hit);  // no client page

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld <= 1'b0;
    end else begin
      req_vld <= take;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (take) begin
      req_read    <= ~core_req.write;
      req_nposted <= core_req.nposted;
    end
  end

  // posted writes get nothing back
  assign resp_vld_nxt  = req_vld & (req_read | req_nposted);
  assign resp_type_nxt = (~req_read & req_nposted) ? resp_write : resp_read;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_valid <= 1'b0;
      resp_type  <= resp_read;
    end else begin
      resp_valid <= resp_vld_nxt;
      if (resp_vld_nxt) begin
        resp_type <= resp_type_nxt;
      end
    end
  end

  always_comb begin
    resp_pd                = '0;        // read data zero
    resp_pd[resp_err_bit]  = 1'b0;      // never an error
    resp_pd[resp_type_bit] = resp_type;
  end

endmodule

// File: design/csb_resp_gather.sv
`timescale 1ns/100ps

module csb_resp_gather (
  input  logic                               nvdla_core_clk,
  input  logic                               nvdla_core_rstn,
  input  logic [csb_pkg::num_clients-1:0]    client_resp_valid,
  input  csb_pkg::resp_pd_t                  client_resp_pd [csb_pkg::num_clients],
  input  logic                               dummy_resp_valid,
  input  csb_pkg::resp_pd_t                  dummy_resp_pd,
  output logic                               nvdla2csb_valid,
  output logic                               nvdla2csb_wr_complete,
  output csb_pkg::csb_data_t                 nvdla2csb_data
);
  import csb_pkg::*;

  logic [num_clients-1:0] resp_vld_q;
  resp_pd_t               resp_pd_q [num_clients];
  resp_pd_t               merged_pd;
  logic                   merged_vld;
  logic                   is_read;
  logic                   is_write;

  ////////////////////////////////////////////////////////////
  // client response registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_vld_q <= '0;
    end else begin
      resp_vld_q <= client_resp_valid;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    for (int i = 0; i < num_clients; i++) begin
      if (client_resp_valid[i]) begin
        resp_pd_q[i] <= client_resp_pd[i];
      end
    end
  end

  // masked OR, at most one source live per cycle
  always_comb begin
    merged_pd = {resp_pd_w{dummy_resp_valid}} & dummy_resp_pd;
    for (int i = 0; i < num_clients; i++) begin
      merged_pd = merged_pd | ({resp_pd_w{resp_vld_q[i]}} & resp_pd_q[i]);
    end
  end

  assign merged_vld = (|resp_vld_q) | dummy_resp_valid;
  assign is_read    = merged_vld & (resp_type_e'(merged_pd[resp_type_bit]) == resp_read);
  assign is_write   = merged_vld & (resp_type_e'(merged_pd[resp_type_bit]) == resp_write);

  ////////////////////////////////////////////////////////////
  // host return
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      nvdla2csb_valid       <= 1'b0;
      nvdla2csb_wr_complete <= 1'b0;
      nvdla2csb_data        <= '0;
    end else begin
      nvdla2csb_valid       <= is_read;
      nvdla2csb_wr_complete <= is_write;
      if (is_read) begin
        nvdla2csb_data <= merged_pd[data_w-1:0];  // holds otherwise
      end
    end
  end

  a_resp_onehot: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $onehot0({client_resp_valid, dummy_resp_valid}))
    else $error("csb gather: more than one response valid in a cycle");

endmodule

// File: design/csb_master.sv
`timescale 1ns/100ps

module csb_master (
  input  logic                            nvdla_core_clk,
  input  logic                            nvdla_core_rstn,

  // host request
  input  logic                            csb2nvdla_valid,
  input  csb_pkg::csb_addr_t              csb2nvdla_addr,
  input  csb_pkg::csb_data_t              csb2nvdla_wdat,
  input  logic                            csb2nvdla_write,
  input  logic                            csb2nvdla_nposted,

  // host return
  output logic                            nvdla2csb_valid,
  output csb_pkg::csb_data_t              nvdla2csb_data,
  output logic                            nvdla2csb_wr_complete,

  // clients, index 0..3 is cfgrom, glb, mcif, cdma
  output logic [csb_pkg::num_clients-1:0] client_req_pvld,
  input  logic [csb_pkg::num_clients-1:0] client_req_prdy,
  output csb_pkg::req_pd_t                client_req_pd [csb_pkg::num_clients],
  input  logic [csb_pkg::num_clients-1:0] client_resp_valid,
  input  csb_pkg::resp_pd_t               client_resp_pd [csb_pkg::num_clients]
);
  import csb_pkg::*;

  logic     dummy_resp_valid;
  resp_pd_t dummy_resp_pd;

  csb_core_req_if core_req ();

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////
  csb_req_capture u_capture (
    .nvdla_core_clk    (nvdla_core_clk),
    .nvdla_core_rstn   (nvdla_core_rstn),
    .csb2nvdla_valid   (csb2nvdla_valid),
    .csb2nvdla_write   (csb2nvdla_write),
    .csb2nvdla_nposted (csb2nvdla_nposted),
    .csb2nvdla_addr    (csb2nvdla_addr),
    .csb2nvdla_wdat    (csb2nvdla_wdat),
    .core_req          (core_req)
  );

  ////////////////////////////////////////////////////////////
  // processing
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < num_clients; i++) begin : g_slot
    csb_client_slot #(
      .client_idx (i)
    ) u_slot (
      .nvdla_core_clk  (nvdla_core_clk),
      .nvdla_core_rstn (nvdla_core_rstn),
      .core_req        (core_req),
      .req_pvld        (client_req_pvld[i]),
      .req_prdy        (client_req_prdy[i]),
      .req_pd          (client_req_pd[i])
    );
  end

  csb_dummy_client u_dummy (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .core_req        (core_req),
    .resp_valid      (dummy_resp_valid),
    .resp_pd         (dummy_resp_pd)
  );

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////
  csb_resp_gather u_gather (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .client_resp_valid     (client_resp_valid),
    .client_resp_pd        (client_resp_pd),
    .dummy_resp_valid      (dummy_resp_valid),
    .dummy_resp_pd         (dummy_resp_pd),
    .nvdla2csb_valid       (nvdla2csb_valid),
    .nvdla2csb_wr_complete (nvdla2csb_wr_complete),
    .nvdla2csb_data        (nvdla2csb_data)
  );

endmodule

// File: testbench/tb_csb_vectors.svh
// columns: addr, wdat, write, nposted, target, resp
// target is client 0..3 (cfgrom, glb, mcif, cdma) or dummy_sel, resp marks a host pulse

localparam int num_vectors = 20;

localparam vec_t vec_tab [num_vectors] = '{
  // page 0..3, one of each kind
  '{16'h0010, 32'h1357_9bdf, 1'b0, 1'b0, 3'd0,      1'b1},
  '{16'h0404, 32'hdead_beef, 1'b1, 1'b1, 3'd1,      1'b1},
  '{16'h0808, 32'h0f0f_0f0f, 1'b1, 1'b0, 3'd2,      1'b0},  // posted, no return
  '{16'h0c0c, 32'ha5a5_5a5a, 1'b0, 1'b0, 3'd3,      1'b1},
  // page edges
  '{16'h03ff, 32'hffff_ffff, 1'b0, 1'b0, 3'd0,      1'b1},
  '{16'h07fe, 32'h0000_0000, 1'b0, 1'b0, 3'd1,      1'b1},
  '{16'h0bfd, 32'h1234_5678, 1'b1, 1'b1, 3'd2,      1'b1},
  '{16'h0ffc, 32'h8765_4321, 1'b1, 1'b0, 3'd3,      1'b0},
  // unmapped pages
  '{16'h1000, 32'hcafe_f00d, 1'b0, 1'b0, dummy_sel, 1'b1},
  '{16'h1400, 32'h0bad_cafe, 1'b1, 1'b1, dummy_sel, 1'b1},
  '{16'hfc00, 32'h5555_aaaa, 1'b1, 1'b0, dummy_sel, 1'b0},
  '{16'hffff, 32'h7777_7777, 1'b0, 1'b0, dummy_sel, 1'b1},
  // mixed
  '{16'h0000, 32'h2468_ace0, 1'b1, 1'b1, 3'd0,      1'b1},
  '{16'h0555, 32'h0123_4567, 1'b0, 1'b0, 3'd1,      1'b1},
  '{16'h0a00, 32'h89ab_cdef, 1'b0, 1'b0, 3'd2,      1'b1},
  '{16'h0e00, 32'hfedc_ba98, 1'b1, 1'b1, 3'd3,      1'b1},
  '{16'h2a00, 32'h3c3c_c3c3, 1'b0, 1'b0, dummy_sel, 1'b1},
  '{16'h0123, 32'h7654_3210, 1'b1, 1'b0, 3'd0,      1'b0},
  // read with the non-posted flag still returns read data
  '{16'h0900, 32'h6b6b_b6b6, 1'b0, 1'b1, 3'd2,      1'b1},
  '{16'h3000, 32'h1111_2222, 1'b0, 1'b1, dummy_sel, 1'b1}
};

// File: testbench/tb_csb_master.sv
`timescale 1ns/100ps

module tb_csb_master;

  localparam int clk_period = 20;
  localparam int rst_cycles = 16;
  localparam logic [2:0] dummy_sel = 3'd4;  // target value for unmapped pages

  typedef struct packed {
    logic [15:0] addr;
    logic [31:0] wdat;
    logic        write;
    logic        nposted;
    logic [2:0]  target;   // client 0..3 or dummy_sel
    logic        resp;     // host return pulse expected
  } vec_t;

  `include "tb_csb_vectors.svh"

  localparam int timeout_cycles = num_vectors * 40 + rst_cycles;

  logic        nvdla_core_clk;
  logic        nvdla_core_rstn;
  logic        csb2nvdla_valid;
  logic [15:0] csb2nvdla_addr;
  logic [31:0] csb2nvdla_wdat;
  logic        csb2nvdla_write;
  logic        csb2nvdla_nposted;
  logic        nvdla2csb_valid;
  logic [31:0] nvdla2csb_data;
  logic        nvdla2csb_wr_complete;
  logic [3:0]  client_req_pvld;
  logic [3:0]  client_req_prdy;
  logic [62:0] client_req_pd [4];
  logic [3:0]  client_resp_valid;
  logic [33:0] client_resp_pd [4];

  // client model state
  logic [15:0] lfsr;
  logic [3:0]  last_pvld;
  logic [62:0] last_pd [4];
  logic [31:0] held_data;

  int   cyc;
  int   errors;
  int   checks;
  int   issue_cyc;
  int   resp_cyc;
  int   accept_cnt;
  int   valid_cnt;
  int   wrc_cnt;
  vec_t cur;

  always #(clk_period / 2) nvdla_core_clk = ~nvdla_core_clk;

  csb_master dut_i (.*);

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // {7'b0, nposted, write, wdat, 6'b0, addr}
  function automatic logic [62:0] pack_request(vec_t v);
    logic [62:0] pd;
    pd        = '0;
    pd[15:0]  = v.addr;
    pd[53:22] = v.wdat;
    pd[54]    = v.write;
    pd[55]    = v.nposted;
    return pd;
  endfunction

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_cond(logic ok, string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("ERROR t=%0t %s", $time, what);
    end
  endtask

  task automatic check_idle();
    check_value("client_req_pvld", 64'd0, 64'(client_req_pvld));
    check_value("nvdla2csb_valid", 64'd0, 64'(nvdla2csb_valid));
    check_value("nvdla2csb_wr_complete", 64'd0, 64'(nvdla2csb_wr_complete));
    check_value("nvdla2csb_data", 64'd0, 64'(nvdla2csb_data));
  endtask

  ////////////////////////////////////////////////////////////
  // client models and host monitor run once per falling edge
  ////////////////////////////////////////////////////////////
  task automatic run_clients();
    for (int i = 0; i < 4; i++) begin
      client_resp_valid[i] = 1'b0;
      client_resp_pd[i]    = '0;
      if (last_pvld[i] && client_req_prdy[i]) begin  // transfer at the last edge
        accept_cnt++;
        check_value($sformatf("client_req_pd[%0d]", i), 64'(pack_request(cur)),
                    64'(last_pd[i]));
        if (!last_pd[i][54]) begin
          client_resp_valid[i] = 1'b1;
          client_resp_pd[i]    = {1'b0, 1'b0, ~last_pd[i][53:22]};  // read data inverted
          resp_cyc             = cyc;
        end else if (last_pd[i][55]) begin
          client_resp_valid[i] = 1'b1;
          client_resp_pd[i]    = {1'b1, 1'b0, 32'h0};              // completion
          resp_cyc             = cyc;
        end
      end else if (last_pvld[i]) begin
        // stalled so the request holds
        check_value($sformatf("client_req_pvld[%0d]", i), 64'd1, 64'(client_req_pvld[i]));
        check_value($sformatf("client_req_pd[%0d]", i), 64'(pack_request(cur)),
                    64'(client_req_pd[i]));
      end
      if (client_req_pvld[i] && !last_pvld[i]) begin
        check_cond(int'(cur.target) == i,
                   $sformatf("request appeared on client %0d, target is %0d", i, cur.target));
        check_cond(cyc == issue_cyc + 3,
                   $sformatf("client %0d request valid at cycle %0d, expected cycle %0d",
                             i, cyc, issue_cyc + 3));
      end
      client_req_prdy[i] = lfsr[0];
      lfsr               = lfsr_next(lfsr);
      last_pvld[i]       = client_req_pvld[i];
      last_pd[i]         = client_req_pd[i];
    end
  endtask

  task automatic watch_host();
    logic [31:0] exp_data;
    int          exp_cyc;
    exp_data = (cur.target == dummy_sel) ? 32'h0 : ~cur.wdat;
    exp_cyc  = (cur.target == dummy_sel) ? issue_cyc + 4 : resp_cyc + 2;
    if (nvdla2csb_valid) begin
      valid_cnt++;
      check_value("nvdla2csb_data", 64'(exp_data), 64'(nvdla2csb_data));
      check_cond(cyc == exp_cyc,
                 $sformatf("read return at cycle %0d, expected cycle %0d", cyc, exp_cyc));
      held_data = exp_data;
    end
    if (nvdla2csb_wr_complete) begin
      wrc_cnt++;
      check_value("nvdla2csb_data", 64'(held_data), 64'(nvdla2csb_data));  // must hold
      check_cond(cyc == exp_cyc,
                 $sformatf("write completion at cycle %0d, expected cycle %0d", cyc, exp_cyc));
    end
  endtask

  task automatic tick();
    @(negedge nvdla_core_clk);
    cyc++;
    run_clients();
    watch_host();
  endtask

  function automatic bit entry_done();
    if (cur.target == dummy_sel) begin
      return cyc >= issue_cyc + 4;
    end
    return (accept_cnt > 0) && (!cur.resp || (valid_cnt + wrc_cnt > 0));
  endfunction

  task automatic apply_vector(vec_t v);
    int exp_acc;
    int exp_rd;
    int exp_wr;
    exp_acc    = (v.target == dummy_sel) ? 0 : 1;
    exp_rd     = (v.resp && !v.write) ? 1 : 0;
    exp_wr     = (v.resp && v.write) ? 1 : 0;
    cur        = v;
    accept_cnt = 0;
    valid_cnt  = 0;
    wrc_cnt    = 0;
    resp_cyc   = -100;
    tick();
    issue_cyc         = cyc;
    csb2nvdla_valid   = 1'b1;
    csb2nvdla_addr    = v.addr;
    csb2nvdla_wdat    = v.wdat;
    csb2nvdla_write   = v.write;
    csb2nvdla_nposted = v.nposted;
    tick();
    csb2nvdla_valid = 1'b0;
    while (!entry_done()) begin
      tick();
    end
    repeat (4) tick();  // room for stray pulses
    check_value("client_req_pvld transfers", 64'(exp_acc), 64'(accept_cnt));
    check_value("nvdla2csb_valid pulses", 64'(exp_rd), 64'(valid_cnt));
    check_value("nvdla2csb_wr_complete pulses", 64'(exp_wr), 64'(wrc_cnt));
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    nvdla_core_clk    = 1'b0;
    nvdla_core_rstn   = 1'b0;
    csb2nvdla_valid   = 1'b0;
    csb2nvdla_addr    = '0;
    csb2nvdla_wdat    = '0;
    csb2nvdla_write   = 1'b0;
    csb2nvdla_nposted = 1'b0;
    client_req_prdy   = '0;
    client_resp_valid = '0;
    for (int i = 0; i < 4; i++) begin
      client_resp_pd[i] = '0;
      last_pd[i]        = '0;
    end
    last_pvld = '0;
    held_data = '0;
    lfsr      = 16'd40;
    cyc       = 0;
    errors    = 0;
    checks    = 0;
    issue_cyc = 0;
    resp_cyc  = -100;

    repeat (rst_cycles) begin
      @(negedge nvdla_core_clk);
      cyc++;
      check_idle();
    end
    nvdla_core_rstn = 1'b1;
    repeat (2) begin
      @(negedge nvdla_core_clk);
      cyc++;
      check_idle();
    end

    for (int k = 0; k < num_vectors; k++) begin
      apply_vector(vec_tab[k]);
    end
    repeat (4) tick();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeout_cycles * clk_period);
    $display("watchdog expired after %0d cycles, run did not complete", timeout_cycles);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("tests failed");
    $finish;
  end

endmodule

// File: src.f
+incdir+testbench
design/csb_pkg.sv
design/csb_core_req_if.sv
design/csb_req_capture.sv
design/csb_client_slot.sv
design/csb_dummy_client.sv
design/csb_resp_gather.sv
design/csb_master.sv
testbench/tb_csb_master.sv

// File: run_sim.sh
#!/bin/sh
# build and run the csb master testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
  --top-module tb_csb_master -f src.f -o tb_csb_master
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_csb_master > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$log"; then
  exit 1
fi

exit 0
